//--- common/hc_pkg.sv
/*
 * Shared widths and types for the host ring reader.
 * The ring size must be a power of two so that indices wrap on their own.
 * Addresses count whole lines, not bytes. ROB_ENTRIES must be a power of two.
 */

package hc_pkg;

    // ========================================
    // Ring and line geometry
    // ========================================

    // A 64-line ring in host memory
    localparam int unsigned RING_IDX_BITS = 6;

    // Kept narrow so that simulation stays fast
    localparam int unsigned LINE_BITS = 64;

    // One address unit is one line
    localparam int unsigned ADDR_BITS = 32;

    // ========================================
    // Reorder scoreboard
    // ========================================

    // Number of reads that may be in flight or waiting for delivery
    localparam int unsigned ROB_ENTRIES = 16;

    // The slot index doubles as the read tag on the memory channel
    localparam int unsigned ROB_IDX_BITS = $clog2(ROB_ENTRIES);

    // ========================================
    // Status reporting
    // ========================================

    // Minimum spacing in cycles between two reports to the host
    localparam int unsigned STATUS_INTERVAL = 8;

    // Counter wide enough to hold STATUS_INTERVAL itself, where it saturates
    localparam int unsigned STATUS_CNT_BITS = $clog2(STATUS_INTERVAL + 1);

    // Index into the ring
    typedef logic [RING_IDX_BITS-1:0] t_ring_idx;

    // One line of payload
    typedef logic [LINE_BITS-1:0] t_line;

    // Line address in host memory
    typedef logic [ADDR_BITS-1:0] t_line_addr;

    // Scoreboard slot, also used as the read tag
    typedef logic [ROB_IDX_BITS-1:0] t_rob_idx;

    // Cycles since the last status report
    typedef logic [STATUS_CNT_BITS-1:0] t_status_cnt;

endpackage

//--- rtl/fifo2.sv
/*
 * Two-entry registered FIFO for the outgoing line stream.
 * The caller must not enqueue while not_full is low or dequeue while
 * not_empty is low. Enqueue and dequeue in the same cycle are allowed.
 */
`timescale 1ns/1ps

module fifo2
(
    input  logic          clk,
    input  logic          reset_n,

    input  hc_pkg::t_line enq_data,
    input  logic          enq_en,
    output logic          not_full,

    output hc_pkg::t_line first,
    input  logic          deq_en,
    output logic          not_empty
);

    // Storage holds no reset, only the pointers and the count do
    hc_pkg::t_line mem [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    assign not_full  = (count != 2'd2);
    assign not_empty = (count != 2'd0);

    // The head comes straight out of a register, so the client sees no logic
    assign first = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= ~wr_ptr;
            end

            if (deq_en)
            begin
                rd_ptr <= ~rd_ptr;
            end

            // A simultaneous enqueue and dequeue leaves the count alone
            case ({enq_en, deq_en})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- fifo_from_host/rob_scoreboard.sv
/*
 * Reorder scoreboard. Slots are allocated in request order, filled in any
 * order and released in allocation order once the head slot is filled.
 * alloc_en is only legal while not_full is high, and each slot is filled once.
 */
`timescale 1ns/1ps

module rob_scoreboard
(
    input  logic             clk,
    input  logic             reset_n,

    // Allocation side, driven by request grants
    input  logic             alloc_en,
    output logic             not_full,
    output hc_pkg::t_rob_idx alloc_idx,

    // Fill side, driven by tagged responses
    input  logic             fill_en,
    input  hc_pkg::t_rob_idx fill_idx,
    input  hc_pkg::t_line    fill_data,

    // Release side, in request order
    input  logic             deq_en,
    output logic             not_empty,
    output hc_pkg::t_line    first
);

    // ========================================
    // Slot state
    // ========================================

    // Pointers carry one extra bit so that full and empty can be told apart
    logic [hc_pkg::ROB_IDX_BITS:0] alloc_ptr;
    logic [hc_pkg::ROB_IDX_BITS:0] head_ptr;

    // Set when a slot holds a response that has not been released yet
    logic [hc_pkg::ROB_ENTRIES-1:0] filled;

    // Response payload, one line per slot
    hc_pkg::t_line slot_data [hc_pkg::ROB_ENTRIES];

    hc_pkg::t_rob_idx head_idx;

    assign alloc_idx = alloc_ptr[hc_pkg::ROB_IDX_BITS-1:0];
    assign head_idx  = head_ptr[hc_pkg::ROB_IDX_BITS-1:0];

    // Full when the low bits match but the wrap bits differ
    assign not_full = !((alloc_ptr[hc_pkg::ROB_IDX_BITS] != head_ptr[hc_pkg::ROB_IDX_BITS]) &&
                        (alloc_idx == head_idx));

    // Only the head may leave, and only once its data is in.
    // A filled head is always an allocated slot, so no separate empty check
    // is needed here
    assign not_empty = filled[head_idx];
    assign first     = slot_data[head_idx];

    // ========================================
    // Pointer and filled-bit updates
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            head_ptr  <= '0;
        end
        else
        begin
            if (alloc_en)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (deq_en)
            begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filled <= '0;
        end
        else
        begin
            // The released slot becomes free for a later allocation
            if (deq_en)
            begin
                filled[head_idx] <= 1'b0;
            end

            // A response lands in its slot on the cycle it arrives.
            // It can never target the head being released, since that slot
            // is already filled
            if (fill_en)
            begin
                filled[fill_idx] <= 1'b1;
            end
        end
    end

    // Payload write, indexed by the response tag
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            slot_data[fill_idx] <= fill_data;
        end
    end

endmodule

//--- fifo_from_host/fifo_from_host.sv
/*
 * Ring reader. Issues one line read per grant while the ring holds unread
 * lines and a scoreboard slot is free, then delivers lines in ring order.
 * ring_base needs no alignment; the ring size must be a power of two.
 */
`timescale 1ns/1ps

module fifo_from_host
(
    input  logic               clk,
    input  logic               reset_n,

    input  hc_pkg::t_line_addr ring_base,
    input  hc_pkg::t_ring_idx  newest_idx,
    output hc_pkg::t_ring_idx  oldest_idx,

    // Request channel toward memory
    output logic               read_request,
    output hc_pkg::t_line_addr read_addr,
    output hc_pkg::t_rob_idx   read_tag,
    input  logic               read_grant,

    // Tagged responses that may arrive out of order
    input  logic               rsp_valid,
    input  hc_pkg::t_rob_idx   rsp_tag,
    input  hc_pkg::t_line      rsp_data,

    // Client side
    output hc_pkg::t_line      rx_data,
    output logic               rx_rdy,
    input  logic               rx_enable
);

    // Ring index of the next line to request
    hc_pkg::t_ring_idx next_read_idx;

    // Scoreboard to output FIFO path
    logic             sc_not_full;
    logic             sc_not_empty;
    hc_pkg::t_rob_idx sc_alloc_idx;
    hc_pkg::t_line    sc_first;
    logic             out_not_full;
    logic             out_enq_en;

    // ========================================
    // Request generation
    // ========================================

    // Unread lines exist while our pointer trails the doorbell
    assign read_request = (next_read_idx != newest_idx) && sc_not_full;

    // Adding the index to the base lets the ring sit anywhere in memory
    assign read_addr = ring_base + hc_pkg::t_line_addr'(next_read_idx);

    // The tag names the slot that the response must fill
    assign read_tag = sc_alloc_idx;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            next_read_idx <= '0;
        end
        else if (read_grant)
        begin
            // Wraps at the end of the ring
            next_read_idx <= next_read_idx + 1'b1;
        end
    end

    // ========================================
    // Reordering and delivery
    // ========================================

    rob_scoreboard scoreboard
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .alloc_en  (read_grant),
        .not_full  (sc_not_full),
        .alloc_idx (sc_alloc_idx),
        .fill_en   (rsp_valid),
        .fill_idx  (rsp_tag),
        .fill_data (rsp_data),
        .deq_en    (out_enq_en),
        .not_empty (sc_not_empty),
        .first     (sc_first)
    );

    // Move the head line whenever the output FIFO has room
    assign out_enq_en = sc_not_empty && out_not_full;

    fifo2 out_q
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (sc_first),
        .enq_en    (out_enq_en),
        .not_full  (out_not_full),
        .first     (rx_data),
        .deq_en    (rx_enable),
        .not_empty (rx_rdy)
    );

    // Oldest index counts lines as they leave the scoreboard in ring order
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest_idx <= '0;
        end
        else if (out_enq_en)
        begin
            oldest_idx <= oldest_idx + 1'b1;
        end
    end

endmodule

//--- rtl/status_manager.sv
/*
 * Holds the host doorbell index and reports the oldest unconsumed index
 * back to the host. Reports are throttled to one per STATUS_INTERVAL cycles
 * and are sent only when the index has moved.
 */
`timescale 1ns/1ps

module status_manager
(
    input  logic              clk,
    input  logic              reset_n,

    input  logic              doorbell_valid,
    input  hc_pkg::t_ring_idx doorbell_idx,
    output hc_pkg::t_ring_idx newest_idx,

    input  hc_pkg::t_ring_idx oldest_idx,
    output logic              status_valid,
    output hc_pkg::t_ring_idx status_oldest
);

    // Last value sent to the host, held on the report port
    hc_pkg::t_ring_idx   last_reported;
    hc_pkg::t_status_cnt interval_cnt;
    logic                report_now;

    assign status_oldest = last_reported;

    // The count includes the cycle in which the report would appear
    assign report_now = (oldest_idx != last_reported) &&
                        (interval_cnt >= hc_pkg::t_status_cnt'(hc_pkg::STATUS_INTERVAL));

    // The newest doorbell wins, earlier ones are simply overwritten
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            newest_idx <= '0;
        end
        else if (doorbell_valid)
        begin
            newest_idx <= doorbell_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            last_reported <= '0;
            status_valid  <= 1'b0;
            // Start saturated so the first movement is reported at once
            interval_cnt  <= hc_pkg::t_status_cnt'(hc_pkg::STATUS_INTERVAL);
        end
        else
        begin
            status_valid <= report_now;

            if (report_now)
            begin
                last_reported <= oldest_idx;
                interval_cnt  <= hc_pkg::t_status_cnt'(1);
            end
            else if (interval_cnt < hc_pkg::t_status_cnt'(hc_pkg::STATUS_INTERVAL))
            begin
                interval_cnt <= interval_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/hc_top.sv
/*
 * Top level of the host ring reader. Connects the status manager and the
 * reader to the memory channel, the client and the host status port.
 */
`timescale 1ns/1ps

module hc_top
(
    input  logic               clk,
    input  logic               reset_n,

    // Ring location and host doorbell
    input  hc_pkg::t_line_addr ring_base,
    input  logic               doorbell_valid,
    input  hc_pkg::t_ring_idx  doorbell_idx,

    // Memory request channel
    output logic               read_request,
    output hc_pkg::t_line_addr read_addr,
    output hc_pkg::t_rob_idx   read_tag,
    input  logic               read_grant,

    // Memory responses
    input  logic               rsp_valid,
    input  hc_pkg::t_rob_idx   rsp_tag,
    input  hc_pkg::t_line      rsp_data,

    // FPGA-side client
    output hc_pkg::t_line      rx_data,
    output logic               rx_rdy,
    input  logic               rx_enable,

    // Status reports to the host
    output logic               status_valid,
    output hc_pkg::t_ring_idx  status_oldest
);

    // Doorbell index toward the reader, consumed index back from it
    hc_pkg::t_ring_idx newest_idx;
    hc_pkg::t_ring_idx oldest_idx;

    status_manager status_mgr
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .doorbell_valid (doorbell_valid),
        .doorbell_idx   (doorbell_idx),
        .newest_idx     (newest_idx),
        .oldest_idx     (oldest_idx),
        .status_valid   (status_valid),
        .status_oldest  (status_oldest)
    );

    fifo_from_host reader
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .ring_base    (ring_base),
        .newest_idx   (newest_idx),
        .oldest_idx   (oldest_idx),
        .read_request (read_request),
        .read_addr    (read_addr),
        .read_tag     (read_tag),
        .read_grant   (read_grant),
        .rsp_valid    (rsp_valid),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .rx_data      (rx_data),
        .rx_rdy       (rx_rdy),
        .rx_enable    (rx_enable)
    );

endmodule

//--- tb/host_mem_model.sv
/*
 * Behavioral host memory for the ring reader testbench.
 * Grants pending requests at random and returns each granted line once,
 * after a random delay and in random order. Line data is the address XORed
 * with a fixed key, written twice. Outputs change on the falling clock edge.
 */
`timescale 1ns/1ps

module host_mem_model
(
    input  logic               clk,

    input  logic               read_request,
    input  hc_pkg::t_line_addr read_addr,
    input  hc_pkg::t_rob_idx   read_tag,
    output logic               read_grant,

    output logic               rsp_valid,
    output hc_pkg::t_rob_idx   rsp_tag,
    output hc_pkg::t_line      rsp_data
);

    // Driven values, quiet from time zero
    logic             grant_q     = 1'b0;
    logic             rsp_valid_q = 1'b0;
    hc_pkg::t_rob_idx rsp_tag_q   = '0;
    hc_pkg::t_line    rsp_data_q  = '0;

    // Granted reads that still owe a response
    hc_pkg::t_rob_idx   pend_tag[$];
    hc_pkg::t_line_addr pend_addr[$];
    int                 pend_wait[$];

    int unsigned rng_state = 32'd79;

    assign read_grant = grant_q;
    assign rsp_valid  = rsp_valid_q;
    assign rsp_tag    = rsp_tag_q;
    assign rsp_data   = rsp_data_q;

    // Linear congruential generator, upper bits only
    function int unsigned rand_below(input int unsigned limit);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return (rng_state >> 16) % limit;
    endfunction

    always @(negedge clk)
    begin : serve_memory
        int pick;

        // Age every pending read by one cycle
        for (int i = 0; i < pend_wait.size(); i++)
        begin
            if (pend_wait[i] > 0)
            begin
                pend_wait[i] = pend_wait[i] - 1;
            end
        end

        // Try one random entry per cycle, so ready reads leave in any order
        rsp_valid_q = 1'b0;
        if (pend_tag.size() > 0)
        begin
            pick = int'(rand_below(pend_tag.size()));
            if (pend_wait[pick] == 0)
            begin
                rsp_valid_q = 1'b1;
                rsp_tag_q   = pend_tag[pick];
                rsp_data_q  = {pend_addr[pick] ^ 32'h5A3C_96E1, pend_addr[pick] ^ 32'h5A3C_96E1};
                pend_tag.delete(pick);
                pend_addr.delete(pick);
                pend_wait.delete(pick);
            end
        end

        // A new grant waits at least one cycle before its response
        grant_q = 1'b0;
        if (read_request === 1'b1 && rand_below(4) != 0)
        begin
            grant_q = 1'b1;
            pend_tag.push_back(read_tag);
            pend_addr.push_back(read_addr);
            pend_wait.push_back(1 + int'(rand_below(20)));
        end
    end

endmodule

//--- tb/tb_hc_top.sv
/*
 * Testbench for the host ring reader. Rings doorbells in random steps,
 * drains the client port at random with one long stall, and checks line
 * order, request rules and status reports with immediate assertions.
 * The host never runs more than 63 lines ahead of the client.
 */
`timescale 1ns/1ps

module tb_hc_top;

    // ========================================
    // Run length and data key
    // ========================================

    localparam int          TOTAL_LINES  = 200;
    localparam int          STALL_CYCLES = 200;
    localparam int          WAIT_LIMIT   = 5000;
    localparam logic [31:0] DATA_KEY     = 32'h5A3C_96E1;

    logic               clk            = 1'b0;
    logic               reset_n        = 1'b0;
    hc_pkg::t_line_addr ring_base      = 32'hFFFF_FFE7;
    logic               doorbell_valid = 1'b0;
    hc_pkg::t_ring_idx  doorbell_idx   = '0;
    logic               rx_enable      = 1'b0;

    logic               read_request;
    hc_pkg::t_line_addr read_addr;
    hc_pkg::t_rob_idx   read_tag;
    logic               read_grant;
    logic               rsp_valid;
    hc_pkg::t_rob_idx   rsp_tag;
    hc_pkg::t_line      rsp_data;
    hc_pkg::t_line      rx_data;
    logic               rx_rdy;
    logic               status_valid;
    hc_pkg::t_ring_idx  status_oldest;

    // Scoreboard of the host and client views
    int written   = 0;
    int requested = 0;
    int consumed  = 0;
    int cycle     = 0;
    int last_report_cycle = 0;
    logic seen_report = 1'b0;
    hc_pkg::t_ring_idx last_status = '0;
    hc_pkg::t_ring_idx host_newest = '0;

    // Held values from the previous edge
    logic               hold_req  = 1'b0;
    hc_pkg::t_line_addr held_addr = '0;
    hc_pkg::t_rob_idx   held_tag  = '0;
    logic               hold_rdy  = 1'b0;
    hc_pkg::t_line      held_data = '0;

    // Stimulus control that changes on the rising edge only
    logic drive_on     = 1'b0;
    logic client_stall = 1'b0;

    int unsigned rng_state = 32'd79;

    hc_top UUT
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .ring_base      (ring_base),
        .doorbell_valid (doorbell_valid),
        .doorbell_idx   (doorbell_idx),
        .read_request   (read_request),
        .read_addr      (read_addr),
        .read_tag       (read_tag),
        .read_grant     (read_grant),
        .rsp_valid      (rsp_valid),
        .rsp_tag        (rsp_tag),
        .rsp_data       (rsp_data),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable),
        .status_valid   (status_valid),
        .status_oldest  (status_oldest)
    );

    host_mem_model memory
    (
        .clk          (clk),
        .read_request (read_request),
        .read_addr    (read_addr),
        .read_tag     (read_tag),
        .read_grant   (read_grant),
        .rsp_valid    (rsp_valid),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data)
    );

    initial
    begin
        forever #50 clk = ~clk;
    end

    function int unsigned rand_below(input int unsigned limit);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return (rng_state >> 16) % limit;
    endfunction

    // Host rule for line contents
    function automatic hc_pkg::t_line expected_line(input hc_pkg::t_line_addr addr);
        return {2{addr ^ DATA_KEY}};
    endfunction

    task automatic report_failure(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped on a timeout");
    endtask

    task automatic wait_for_consumed(input int target);
        int waited;
        waited = 0;
        while (consumed < target && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (consumed < target)
        begin
            report_timeout($sformatf("the client to reach %0d lines", target));
        end
    endtask

    // ========================================
    // Input drive on the falling edge
    // ========================================

    always @(negedge clk)
    begin : drive_inputs
        int step;
        doorbell_valid = 1'b0;
        rx_enable      = 1'b0;
        if (drive_on)
        begin
            if (written < TOTAL_LINES && rand_below(4) == 0)
            begin
                step = 1 + int'(rand_below(8));
                // The host may not overwrite lines the client still needs
                if (written + step > consumed + 63)
                begin
                    step = consumed + 63 - written;
                end
                if (written + step > TOTAL_LINES)
                begin
                    step = TOTAL_LINES - written;
                end
                if (step > 0)
                begin
                    written        = written + step;
                    doorbell_valid = 1'b1;
                    doorbell_idx   = hc_pkg::t_ring_idx'(written);
                end
            end
            rx_enable = rx_rdy && !client_stall && (rand_below(3) != 0);
        end
    end

    // ========================================
    // Checks on the rising edge
    // ========================================

    always @(posedge clk)
    begin : check_cycle
        hc_pkg::t_ring_idx status_gap;
        if (reset_n)
        begin
            cycle = cycle + 1;

            assert (!read_grant || read_request)
                else report_failure("grant seen without a request");
            assert (!(read_request && hc_pkg::t_ring_idx'(requested) == host_newest))
                else report_failure($sformatf("request with no unread line, sent %0d", requested));
            if (hold_req)
            begin
                assert (read_request && read_addr == held_addr && read_tag == held_tag)
                    else report_failure("request dropped or changed before its grant");
            end
            hold_req  = read_request && !read_grant;
            held_addr = read_addr;
            held_tag  = read_tag;
            if (read_request && read_grant)
            begin
                requested = requested + 1;
            end
            // Two more lines may wait in the output FIFO beyond the scoreboard
            assert (requested - consumed <= hc_pkg::ROB_ENTRIES + 2)
                else report_failure($sformatf("%0d lines in flight", requested - consumed));

            // A report lags by a cycle and may run ahead by the lines already released
            if (status_valid)
            begin
                status_gap = status_oldest - hc_pkg::t_ring_idx'(consumed) + 1'b1;
                assert (status_gap <= 3)
                    else report_failure($sformatf("status %0d with %0d lines consumed",
                                                  status_oldest, consumed));
                if (seen_report)
                begin
                    assert (cycle - last_report_cycle >= hc_pkg::STATUS_INTERVAL)
                        else report_failure("status reports closer than the interval");
                end
                seen_report       = 1'b1;
                last_report_cycle = cycle;
                last_status       = status_oldest;
            end

            if (hold_rdy)
            begin
                assert (rx_rdy && rx_data == held_data)
                    else report_failure("client line changed while it waited");
            end
            hold_rdy  = rx_rdy && !rx_enable;
            held_data = rx_data;
            if (rx_enable)
            begin
                assert (rx_data == expected_line(ring_base +
                                                 hc_pkg::t_line_addr'(consumed % 64)))
                    else report_failure($sformatf("line %0d read as %h", consumed, rx_data));
                consumed = consumed + 1;
            end

            // The reader sees a doorbell one edge after it is sampled
            if (doorbell_valid)
            begin
                host_newest = doorbell_idx;
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin : run_test
        int waited;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        assert (!read_request && !rx_rdy && !status_valid)
            else report_failure("outputs active right after reset");
        @(posedge clk);
        drive_on = 1'b1;

        // Hold the client off long enough for every slot to fill
        wait_for_consumed(60);
        @(posedge clk);
        client_stall = 1'b1;
        repeat (STALL_CYCLES) @(negedge clk);
        assert (!read_request && rx_rdy)
            else report_failure("reader still requesting with all slots held");
        @(posedge clk);
        client_stall = 1'b0;

        wait_for_consumed(TOTAL_LINES);

        // The last report must catch up with the full count
        waited = 0;
        while (!(seen_report && last_status == hc_pkg::t_ring_idx'(TOTAL_LINES)) &&
               waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!(seen_report && last_status == hc_pkg::t_ring_idx'(TOTAL_LINES)))
        begin
            report_timeout("the final status report");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- sim.f
common/hc_pkg.sv
rtl/fifo2.sv
fifo_from_host/rob_scoreboard.sv
fifo_from_host/fifo_from_host.sv
rtl/status_manager.sv
rtl/hc_top.sv
tb/host_mem_model.sv
tb/tb_hc_top.sv

//--- Makefile
TOP = tb_hc_top
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f sim.f --top-module $(TOP) --Mdir $(OBJ) -o $(TOP)

run: build
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps \
		common/hc_pkg.sv rtl/fifo2.sv \
		fifo_from_host/rob_scoreboard.sv fifo_from_host/fifo_from_host.sv \
		rtl/status_manager.sv rtl/hc_top.sv --top-module hc_top

clean:
	rm -rf $(OBJ) sim.log
